// File: wb_config_pkg.sv
package wb_config_pkg;

  // Number of execution units that compete for the result buses.
  localparam int num_units = 3;

  // Number of shared result buses.
  localparam int num_buses = 2;

  // Owner code of a bus that no unit holds.
  localparam logic [7:0] free_code = 8'hff;

  // Claim codes are combined by AND, so the code with more zeros wins the bus.
  // Unit u uses all ones shifted left by u+1, which makes unit 2 the strongest.
  localparam logic [7:0] unit_prio [num_units] = '{
    8'hff << 1,
    8'hff << 2,
    8'hff << 3
  };

  // Width of the latency field. Latencies run from 1 to 15.
  localparam int lat_width = 4;

endpackage

// File: wb_types_pkg.sv
package wb_types_pkg;

  import wb_config_pkg::*;

  // Owner or claim code on a result bus.
  typedef logic [7:0] prio_code_t;

  // Execution latency in cycles.
  typedef logic [lat_width-1:0] lat_t;

  // Writeback payload. The write flags and jump address pass through unchanged.
  typedef struct packed {
    logic [31:0] data;
    logic [31:0] address;
    logic [31:0] jmp_address;
    logic [5:0]  rd;
    logic [5:0]  rn;
    logic        reg_write;
    logic        cache_write;
  } result_t;

  // One result bus as seen by its consumers.
  typedef struct packed {
    logic    valid;
    result_t result;
  } bus_t;

endpackage

// File: latency_timer.sv
module latency_timer
  import wb_types_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic start,
  input  lat_t latency,
  output logic done
);

  lat_t count;

  // The count is loaded on start and runs down to zero.
  // Done is registered, so it rises exactly latency cycles after the start edge.
  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= (count == lat_t'(1));
      if (start) begin
        count <= latency;
      end else if (count != '0) begin
        count <= count - lat_t'(1);
      end
    end
  end

endmodule

// File: writeback_sequencer.sv
module writeback_sequencer
  import wb_types_pkg::*;
(
  input  logic    clock,
  input  logic    reset,

  input  logic    issue_valid,
  input  result_t issue_result,
  input  lat_t    issue_latency,
  output logic    issue_ready,

  output logic    timer_start,
  output lat_t    timer_latency,
  input  logic    timer_done,

  output logic    get_bus,
  input  logic    granted,
  output result_t held_result
);

  typedef enum logic [1:0] {
    state_idle,
    state_busy,
    state_wait
  } state_t;

  state_t state;
  logic   accept;

  // An issue is taken only while the unit has nothing in flight.
  assign accept = issue_valid && (state == state_idle);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      case (state)
        state_idle: begin
          if (accept) begin
            state <= state_busy;
          end
        end
        state_busy: begin
          if (timer_done) begin
            state <= state_wait;
          end
        end
        state_wait: begin
          // The grant cycle is the one in which the payload goes to the resolver.
          if (granted) begin
            state <= state_idle;
          end
        end
        default: begin
          state <= state_idle;
        end
      endcase
    end
  end

  // The result is held from issue until the bus grant.
  always_ff @(posedge clock) begin
    if (accept) begin
      held_result <= issue_result;
    end
  end

  assign issue_ready   = (state == state_idle);
  assign timer_start   = accept;
  assign timer_latency = issue_latency;

  // The bus is requested for as long as the finished result is waiting.
  assign get_bus = (state == state_wait);

endmodule

// File: bus_arbiter.sv
module bus_arbiter
  import wb_config_pkg::*, wb_types_pkg::*;
#(
  parameter prio_code_t prio = 8'hfe
) (
  input  logic       get_bus,
  input  prio_code_t owner [num_buses],
  output prio_code_t claim [num_buses],
  output logic       granted,
  output logic       grant_bus
);

  logic [num_buses-1:0] acquired;
  logic [num_buses-1:0] free;
  logic [num_buses-1:0] weaker;

  // Returns the lowest set index, or -1 when no bit is set.
  function automatic int first_set(input logic [num_buses-1:0] vec);
    int idx;
    idx = -1;
    for (int b = num_buses - 1; b >= 0; b--) begin
      if (vec[b]) begin
        idx = b;
      end
    end
    return idx;
  endfunction

  // Classify every bus from the registered owner codes.
  always_comb begin
    for (int b = 0; b < num_buses; b++) begin
      acquired[b] = (owner[b] == prio);
      free[b]     = (owner[b] == free_code);
      // A larger code has fewer zeros and so belongs to a weaker unit.
      weaker[b]   = (owner[b] > prio);
    end
  end

  always_comb begin
    int sel;
    sel       = -1;
    granted   = 1'b0;
    grant_bus = 1'b0;
    for (int b = 0; b < num_buses; b++) begin
      claim[b] = free_code;
    end

    if (get_bus) begin
      if (|acquired) begin
        // The bus is ours, so keep claiming it and hand over the payload now.
        sel       = first_set(acquired);
        granted   = 1'b1;
        grant_bus = sel[0];
      end else if (|free) begin
        sel = first_set(free);
      end else if (|weaker) begin
        // Take the bus away from a lower priority unit.
        sel = first_set(weaker);
      end
    end

    if (sel >= 0) begin
      claim[sel] = prio;
    end
  end

endmodule

// File: bus_resolver.sv
module bus_resolver
  import wb_config_pkg::*, wb_types_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  prio_code_t claim [num_units][num_buses],
  input  logic       granted [num_units],
  input  logic       grant_bus [num_units],
  input  result_t    payload [num_units],
  output prio_code_t owner [num_buses],
  output bus_t       result_bus [num_buses]
);

  prio_code_t resolved [num_buses];
  logic       hit [num_buses];
  result_t    winner [num_buses];
  logic       bus_valid [num_buses];
  result_t    bus_result [num_buses];

  // The strongest claim survives the AND, as it would on a wired bus.
  always_comb begin
    for (int b = 0; b < num_buses; b++) begin
      resolved[b] = free_code;
      hit[b]      = 1'b0;
      winner[b]   = '0;
      for (int u = 0; u < num_units; u++) begin
        resolved[b] = resolved[b] & claim[u][b];
        // At most one unit can own a bus, so at most one grant matches.
        if (granted[u] && (int'(grant_bus[u]) == b)) begin
          hit[b]    = 1'b1;
          winner[b] = payload[u];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int b = 0; b < num_buses; b++) begin
        owner[b]     <= free_code;
        bus_valid[b] <= 1'b0;
      end
    end else begin
      for (int b = 0; b < num_buses; b++) begin
        owner[b]     <= resolved[b];
        bus_valid[b] <= hit[b];
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int b = 0; b < num_buses; b++) begin
      if (hit[b]) begin
        bus_result[b] <= winner[b];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < num_buses; b++) begin
      result_bus[b].valid  = bus_valid[b];
      result_bus[b].result = bus_result[b];
    end
  end

endmodule

// File: writeback_top.sv
module writeback_top
  import wb_config_pkg::*, wb_types_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    issue_valid [num_units],
  input  result_t issue_result [num_units],
  input  lat_t    issue_latency [num_units],
  output logic    issue_ready [num_units],
  output bus_t    result_bus [num_buses]
);

  logic       timer_start [num_units];
  lat_t       timer_latency [num_units];
  logic       timer_done [num_units];
  logic       get_bus [num_units];
  result_t    held_result [num_units];
  logic       granted [num_units];
  logic       grant_bus [num_units];
  prio_code_t claim [num_units][num_buses];
  prio_code_t owner [num_buses];

  // One lane per execution unit, each with its own fixed priority code.
  for (genvar u = 0; u < num_units; u++) begin : g_unit
    latency_timer timer_i (
      .clock   (clock),
      .reset   (reset),
      .start   (timer_start[u]),
      .latency (timer_latency[u]),
      .done    (timer_done[u])
    );

    writeback_sequencer seq_i (
      .clock         (clock),
      .reset         (reset),
      .issue_valid   (issue_valid[u]),
      .issue_result  (issue_result[u]),
      .issue_latency (issue_latency[u]),
      .issue_ready   (issue_ready[u]),
      .timer_start   (timer_start[u]),
      .timer_latency (timer_latency[u]),
      .timer_done    (timer_done[u]),
      .get_bus       (get_bus[u]),
      .granted       (granted[u]),
      .held_result   (held_result[u])
    );

    bus_arbiter #(
      .prio (unit_prio[u])
    ) arb_i (
      .get_bus   (get_bus[u]),
      .owner     (owner),
      .claim     (claim[u]),
      .granted   (granted[u]),
      .grant_bus (grant_bus[u])
    );
  end

  bus_resolver resolver_i (
    .clock      (clock),
    .reset      (reset),
    .claim      (claim),
    .granted    (granted),
    .grant_bus  (grant_bus),
    .payload    (held_result),
    .owner      (owner),
    .result_bus (result_bus)
  );

endmodule

// File: tb_writeback.sv
module tb_writeback
  import wb_config_pkg::*, wb_types_pkg::*;
();

  logic    clock;
  logic    reset;
  logic    issue_valid [num_units];
  result_t issue_result [num_units];
  lat_t    issue_latency [num_units];
  logic    issue_ready [num_units];
  bus_t    result_bus [num_buses];

  logic [31:0] seed = 32'h20ed_f7a6;
  int          errors = 0;
  int          checks = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          test_errors_at = 0;
  string       test_name;
  int          edge_count = 0;
  logic        ready_seen [num_units];
  logic        valid_seen [num_buses];

  // Scoreboard of pending results, and the log of matched beats.
  int      exp_unit [$];
  result_t exp_result [$];
  int      exp_edge [$];
  int      got_unit [$];
  int      got_bus [$];
  int      got_delay [$];

  writeback_top dut_i (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_result  (issue_result),
    .issue_latency (issue_latency),
    .issue_ready   (issue_ready),
    .result_bus    (result_bus)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic result_t random_result();
    result_t     r;
    logic [31:0] x;
    x             = next_random();
    r.data        = next_random();
    r.address     = next_random();
    r.jmp_address = next_random();
    r.rd          = x[31:26];
    r.rn          = x[25:20];
    r.reg_write   = x[19];
    r.cache_write = x[18];
    return r;
  endfunction

  // Latencies run from 1 to 15.
  function automatic lat_t random_latency();
    return lat_t'(((next_random() >> 8) % 15) + 1);
  endfunction

  task automatic compare(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_errors_at = errors;
    got_unit.delete();
    got_bus.delete();
    got_delay.delete();
  endtask

  task automatic finish_test();
    if (errors == test_errors_at) begin
      $display("test %s: ok", test_name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", test_name, errors - test_errors_at);
      tests_failed++;
    end
  endtask

  // Beats are seen at the falling edge, half a cycle after the registers load.
  always @(negedge clock) begin : monitor
    int hit;
    edge_count++;
    for (int u = 0; u < num_units; u++) begin
      ready_seen[u] = issue_ready[u];
      if (issue_valid[u] && !issue_ready[u]) begin
        $display("ERROR: unit %0d was issued while it was not ready", u);
        errors++;
      end
    end
    for (int b = 0; b < num_buses; b++) begin
      valid_seen[b] = result_bus[b].valid;
      if (result_bus[b].valid) begin
        hit = -1;
        for (int i = 0; i < exp_result.size(); i++) begin
          if (hit < 0 && exp_result[i] == result_bus[b].result) begin
            hit = i;
          end
        end
        if (hit < 0) begin
          $display("ERROR: bus %0d carried a result that was not pending or came twice", b);
          errors++;
        end else begin
          got_unit.push_back(exp_unit[hit]);
          got_bus.push_back(b);
          got_delay.push_back(edge_count - exp_edge[hit]);
          exp_unit.delete(hit);
          exp_result.delete(hit);
          exp_edge.delete(hit);
        end
      end
    end
  end

  // Inputs driven on one rising edge are taken by the DUT on the next one.
  task automatic issue_units(input logic [num_units-1:0] mask, input lat_t lat);
    int      waited;
    bit      all_ready;
    result_t r;
    waited    = 0;
    all_ready = 1'b0;
    while (!all_ready && waited < 100) begin
      @(posedge clock);
      waited++;
      all_ready = 1'b1;
      for (int u = 0; u < num_units; u++) begin
        if (mask[u] && !ready_seen[u]) begin
          all_ready = 1'b0;
        end
      end
    end
    if (!all_ready) begin
      $display("ERROR: units %b did not become ready within 100 cycles", mask);
      errors++;
    end else begin
      for (int u = 0; u < num_units; u++) begin
        if (mask[u]) begin
          r = random_result();
          issue_valid[u]   <= 1'b1;
          issue_result[u]  <= r;
          issue_latency[u] <= lat;
          exp_unit.push_back(u);
          exp_result.push_back(r);
          exp_edge.push_back(edge_count + 2);
        end
      end
      @(posedge clock);
      for (int u = 0; u < num_units; u++) begin
        issue_valid[u] <= 1'b0;
      end
    end
  endtask

  task automatic wait_beats(input int count, input int limit, input int watch_unit);
    int waited;
    waited = 0;
    while (got_unit.size() < count && waited < limit) begin
      @(posedge clock);
      waited++;
      if (got_unit.size() < count && watch_unit >= 0) begin
        compare($sformatf("%s ready low", test_name), 0, ready_seen[watch_unit]);
      end
    end
    if (got_unit.size() < count) begin
      $display("ERROR: only %0d of %0d results arrived within %0d cycles",
               got_unit.size(), count, limit);
      errors++;
    end
  endtask

  task automatic wait_drained(input int limit);
    int waited;
    bit idle;
    waited = 0;
    idle   = 1'b0;
    while (!idle && waited < limit) begin
      @(posedge clock);
      waited++;
      idle = (exp_result.size() == 0);
      for (int u = 0; u < num_units; u++) begin
        idle = idle && ready_seen[u];
      end
    end
    if (!idle) begin
      $display("ERROR: results were still pending after %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic run_random_traffic(input int count);
    int      issued;
    int      cycles;
    result_t r;
    issued = 0;
    cycles = 0;
    while (issued < count && cycles < 20000) begin
      @(posedge clock);
      cycles++;
      for (int u = 0; u < num_units; u++) begin
        if (issue_valid[u]) begin
          issue_valid[u] <= 1'b0;
        end else if (issued < count && ready_seen[u] && (next_random() >> 12) % 3 == 0) begin
          r = random_result();
          issue_valid[u]   <= 1'b1;
          issue_result[u]  <= r;
          issue_latency[u] <= random_latency();
          exp_unit.push_back(u);
          exp_result.push_back(r);
          exp_edge.push_back(edge_count + 2);
          issued++;
        end
      end
    end
    if (issued < count) begin
      $display("ERROR: only %0d of %0d results were issued in 20000 cycles", issued, count);
      errors++;
    end
    @(posedge clock);
    for (int u = 0; u < num_units; u++) begin
      issue_valid[u] <= 1'b0;
    end
  endtask

  initial begin
    lat_t lat;
    reset = 1'b1;
    for (int u = 0; u < num_units; u++) begin
      issue_valid[u]   = 1'b0;
      issue_result[u]  = '0;
      issue_latency[u] = '0;
      ready_seen[u]    = 1'b0;
    end
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    start_test("reset_state");
    repeat (5) begin
      @(posedge clock);
      for (int u = 0; u < num_units; u++) begin
        compare($sformatf("reset_state ready %0d", u), 1, ready_seen[u]);
      end
      for (int b = 0; b < num_buses; b++) begin
        compare($sformatf("reset_state valid %0d", b), 0, valid_seen[b]);
      end
    end
    finish_test();

    for (int u = 0; u < num_units; u++) begin
      start_test($sformatf("lone_unit_%0d", u));
      lat = random_latency();
      issue_units(num_units'(1 << u), lat);
      wait_beats(1, 40, u);
      if (got_unit.size() > 0) begin
        compare({test_name, " unit"}, u, got_unit[0]);
        compare({test_name, " bus"}, 0, got_bus[0]);
        compare({test_name, " delay"}, lat + 3, got_delay[0]);
        compare({test_name, " ready at beat"}, 1, ready_seen[u]);
      end
      finish_test();
    end

    start_test("priority_order");
    issue_units('1, random_latency());
    wait_beats(3, 60, -1);
    if (got_unit.size() == 3) begin
      compare("priority_order first", 2, got_unit[0]);
      compare("priority_order second", 1, got_unit[1]);
      compare("priority_order third", 0, got_unit[2]);
      compare("priority_order first bus", 0, got_bus[0]);
    end
    finish_test();

    start_test("random_traffic");
    run_random_traffic(300);
    wait_drained(200);
    compare("random_traffic delivered", 300, got_unit.size());
    finish_test();

    start_test("final_state");
    compare("final_state scoreboard", 0, exp_result.size());
    for (int u = 0; u < num_units; u++) begin
      compare($sformatf("final_state ready %0d", u), 1, ready_seen[u]);
    end
    finish_test();

    $display("tests passed: %0d, tests failed: %0d, checks: %0d, errors: %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
wb_config_pkg.sv
wb_types_pkg.sv
latency_timer.sv
writeback_sequencer.sv
bus_arbiter.sv
bus_resolver.sv
writeback_top.sv
tb_writeback.sv
